// File: source/pcore_config.svh
// Core width and reset constants, included by the packages, the fetch PC logic and the testbench
`ifndef PCORE_CONFIG_SVH
`define PCORE_CONFIG_SVH

// Integer register and data path width
`define PCORE_XLEN 32

// Register index width for x0..x31
`define PCORE_REG_ADDR_W 5

// First fetch address after reset
`define PCORE_RESET_PC 32'h0000_1000

`endif

// File: source/pcore_types_pkg.sv
// Basic vector types of the core, imported wherever data words, register indices or PCs appear
`default_nettype none

`include "pcore_config.svh"

package pcore_types_pkg;

    // One integer data word
    typedef logic [`PCORE_XLEN-1:0] type_data_t;

    // Register index, x0 reads as zero and is never a real producer
    typedef logic [`PCORE_REG_ADDR_W-1:0] type_reg_addr_t;

    // Fetch and branch target addresses
    typedef logic [`PCORE_XLEN-1:0] type_pc_t;

endpackage : pcore_types_pkg

`default_nettype wire

// File: source/pcore_fwd_pkg.sv
// Stage summary structs exchanged with the forwarding and stall logic, imported by the hazard slice
`default_nettype none

`include "pcore_config.svh"

package pcore_fwd_pkg;

    import pcore_types_pkg::*;

    // Execute stage view of its own source operands
    typedef struct packed {
        type_reg_addr_t rs1_addr;
        type_reg_addr_t rs2_addr;
        logic           use_rs1;
        logic           use_rs2;
        // Branch or jump resolved in execute
        logic           new_pc_req;
    } type_exe2fwd_s;

    // Memory stage destination and outstanding operations
    typedef struct packed {
        type_reg_addr_t rd_addr;
        logic           rd_wr_req;
        logic           ld_req;
        logic           ld_ack;
        // Multi-cycle multiply started
        logic           mul_req;
    } type_lsu2fwd_s;

    // Writeback destination
    typedef struct packed {
        type_reg_addr_t rd_addr;
        logic           rd_wr_req;
        // Multiply result is ready
        logic           alu_m_res;
    } type_wrb2fwd_s;

    // CSR unit requests
    typedef struct packed {
        // Trap, return or interrupt entry
        logic new_pc_req;
        logic wfi_req;
        // CSR read result sits in the LSU stage
        logic csr_read_req;
    } type_csr2fwd_s;

    // PC update controls for fetch
    typedef struct packed {
        logic exe_new_pc_req;
        logic csr_new_pc_req;
        logic wfi_req;
        logic if_stall;
    } type_fwd2if_s;

    // Operand select toward execute
    typedef struct packed {
        logic fwd_lsu_rs1;
        logic fwd_lsu_rs2;
        logic fwd_wrb_rs1;
        logic fwd_wrb_rs2;
    } type_fwd2exe_s;

    typedef struct packed {
        logic pipe_stall;
    } type_fwd2csr_s;

    // Pipeline register controls for the core top
    typedef struct packed {
        logic if2id_pipe_stall;
        logic if2id_pipe_flush;
        logic id2exe_pipe_stall;
        logic id2exe_pipe_flush;
        logic exe2lsu_pipe_stall;
        logic exe2lsu_pipe_flush;
        logic pipe_fwd_wrb_rs1;
        logic pipe_fwd_wrb_rs2;
    } type_fwd2ptop_s;

endpackage : pcore_fwd_pkg

`default_nettype wire

// File: source/forward_stall.sv
// Data hazard detector that drives operand forwarding, pipeline stalls, flushes and fetch redirects
`default_nettype none

module forward_stall import pcore_fwd_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst_n,

    // Stage summaries
    input  wire type_wrb2fwd_s wrb2fwd_i,
    input  wire type_lsu2fwd_s lsu2fwd_i,
    input  wire type_exe2fwd_s exe2fwd_i,
    input  wire type_csr2fwd_s csr2fwd_i,

    // Controls toward fetch, execute, CSR and the pipeline registers
    output type_fwd2if_s       fwd2if_o,
    output type_fwd2exe_s      fwd2exe_o,
    output type_fwd2csr_s      fwd2csr_o,
    output type_fwd2ptop_s     fwd2ptop_o
);

    logic rs1_valid;
    logic rs2_valid;
    logic lsu_rs1_match;
    logic lsu_rs2_match;
    logic wrb_rs1_match;
    logic wrb_rs2_match;
    logic ld_csr_read_req;
    logic ld_use_hazard;
    logic ld_stall;
    logic ld_stall_ff;
    logic mul_stall;
    logic mul_stall_ff;
    logic exe_new_pc_req;
    logic id_exe_flush;
    logic lsu_flush;
    logic front_stall;

    // x0 never needs forwarding
    assign rs1_valid = |exe2fwd_i.rs1_addr;
    assign rs2_valid = |exe2fwd_i.rs2_addr;

    assign lsu_rs1_match = rs1_valid & lsu2fwd_i.rd_wr_req
                         & (exe2fwd_i.rs1_addr == lsu2fwd_i.rd_addr);
    assign lsu_rs2_match = rs2_valid & lsu2fwd_i.rd_wr_req
                         & (exe2fwd_i.rs2_addr == lsu2fwd_i.rd_addr);
    assign wrb_rs1_match = rs1_valid & wrb2fwd_i.rd_wr_req
                         & (exe2fwd_i.rs1_addr == wrb2fwd_i.rd_addr);
    assign wrb_rs2_match = rs2_valid & wrb2fwd_i.rd_wr_req
                         & (exe2fwd_i.rs2_addr == wrb2fwd_i.rd_addr);

    // LSU result not available yet for loads and CSR reads
    assign ld_csr_read_req = lsu2fwd_i.ld_req | csr2fwd_i.csr_read_req;

    // Ack wins over a new request, so the stall is already low in the ack cycle
    always_comb begin
        if (lsu2fwd_i.ld_ack) begin
            ld_stall = 1'b0;
        end else if (lsu2fwd_i.ld_req) begin
            ld_stall = 1'b1;
        end else begin
            ld_stall = ld_stall_ff;
        end
    end

    always_comb begin
        if (wrb2fwd_i.alu_m_res) begin
            mul_stall = 1'b0;
        end else if (lsu2fwd_i.mul_req) begin
            mul_stall = 1'b1;
        end else begin
            mul_stall = mul_stall_ff;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_stall_ff  <= 1'b0;
            mul_stall_ff <= 1'b0;
        end else begin
            ld_stall_ff  <= ld_stall;
            mul_stall_ff <= mul_stall;
        end
    end

    // Only the first cycle of a load is a load-use hazard, later cycles are the load stall
    assign ld_use_hazard = ((lsu_rs1_match & exe2fwd_i.use_rs1)
                          | (lsu_rs2_match & exe2fwd_i.use_rs2))
                         & ld_csr_read_req & ~ld_stall_ff;

    // Execute redirect is dropped while its operands or the LSU are not settled
    assign exe_new_pc_req = exe2fwd_i.new_pc_req & ~(ld_use_hazard | ld_stall);

    assign lsu_flush    = csr2fwd_i.new_pc_req | csr2fwd_i.wfi_req;
    assign id_exe_flush = exe_new_pc_req | lsu_flush;
    assign front_stall  = ld_use_hazard | ld_stall | mul_stall;

    always_comb begin
        fwd2exe_o.fwd_lsu_rs1 = lsu_rs1_match & ~ld_csr_read_req;
        fwd2exe_o.fwd_lsu_rs2 = lsu_rs2_match & ~ld_csr_read_req;
        fwd2exe_o.fwd_wrb_rs1 = wrb_rs1_match;
        fwd2exe_o.fwd_wrb_rs2 = wrb_rs2_match;
    end

    always_comb begin
        fwd2ptop_o.if2id_pipe_stall   = front_stall;
        fwd2ptop_o.if2id_pipe_flush   = id_exe_flush;
        fwd2ptop_o.id2exe_pipe_stall  = front_stall;
        fwd2ptop_o.id2exe_pipe_flush  = id_exe_flush;
        fwd2ptop_o.exe2lsu_pipe_stall = ld_stall;
        // Bubble into LSU while the dependent instruction waits
        fwd2ptop_o.exe2lsu_pipe_flush = ld_use_hazard | lsu_flush;
        fwd2ptop_o.pipe_fwd_wrb_rs1   = wrb_rs1_match;
        fwd2ptop_o.pipe_fwd_wrb_rs2   = wrb_rs2_match;
    end

    assign fwd2csr_o.pipe_stall = ld_use_hazard;

    always_comb begin
        // CSR redirect has priority over execute
        fwd2if_o.exe_new_pc_req = exe_new_pc_req & ~csr2fwd_i.new_pc_req;
        fwd2if_o.csr_new_pc_req = csr2fwd_i.new_pc_req;
        fwd2if_o.wfi_req        = csr2fwd_i.wfi_req;
        fwd2if_o.if_stall       = front_stall;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !(fwd2if_o.exe_new_pc_req && fwd2if_o.csr_new_pc_req))
        else $error("execute and CSR redirects granted together");

    // The stall flop must mask a repeated load-use hazard in the following cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        ld_stall |=> !ld_use_hazard)
        else $error("load-use hazard raised during an outstanding load");

endmodule : forward_stall

`default_nettype wire

// File: source/operand_bypass.sv
// Execute operand mux choosing between register file, LSU result and writeback result
`default_nettype none

module operand_bypass import pcore_types_pkg::*, pcore_fwd_pkg::*; (
    input  wire type_fwd2exe_s fwd2exe_i,

    // Candidate values for the two sources
    input  wire type_data_t    rf_rs1_data_i,
    input  wire type_data_t    rf_rs2_data_i,
    input  wire type_data_t    lsu_rd_data_i,
    input  wire type_data_t    wrb_rd_data_i,

    // Resolved operands for the ALU
    output type_data_t         rs1_data_o,
    output type_data_t         rs2_data_o
);

    // LSU holds the younger producer, so it is checked first
    function automatic type_data_t pick_operand(
        input logic       sel_lsu,
        input logic       sel_wrb,
        input type_data_t rf_data,
        input type_data_t lsu_data,
        input type_data_t wrb_data
    );
        type_data_t result;
        if (sel_lsu) begin
            result = lsu_data;
        end else if (sel_wrb) begin
            result = wrb_data;
        end else begin
            result = rf_data;
        end
        return result;
    endfunction

    always_comb begin
        rs1_data_o = pick_operand(
            fwd2exe_i.fwd_lsu_rs1,
            fwd2exe_i.fwd_wrb_rs1,
            rf_rs1_data_i,
            lsu_rd_data_i,
            wrb_rd_data_i
        );
    end

    always_comb begin
        rs2_data_o = pick_operand(
            fwd2exe_i.fwd_lsu_rs2,
            fwd2exe_i.fwd_wrb_rs2,
            rf_rs2_data_i,
            lsu_rd_data_i,
            wrb_rd_data_i
        );
    end

endmodule : operand_bypass

`default_nettype wire

// File: source/pc_redirect.sv
// Fetch PC register that steps by one word, takes execute or CSR targets, or holds on a stall
`default_nettype none

`include "pcore_config.svh"

module pc_redirect import pcore_types_pkg::*, pcore_fwd_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst_n,

    // Redirect and stall controls from the hazard detector
    input  wire type_fwd2if_s fwd2if_i,

    // Branch or jump target and trap target
    input  wire type_pc_t     exe_target_i,
    input  wire type_pc_t     csr_target_i,

    output type_pc_t          pc_o
);

    type_pc_t pc_ff;
    type_pc_t pc_next;

    // Priority is CSR, then execute, then hold, then sequential
    always_comb begin
        if (fwd2if_i.csr_new_pc_req) begin
            pc_next = csr_target_i;
        end else if (fwd2if_i.exe_new_pc_req) begin
            pc_next = exe_target_i;
        end else if (fwd2if_i.wfi_req || fwd2if_i.if_stall) begin
            pc_next = pc_ff;
        end else begin
            pc_next = pc_ff + type_pc_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_ff <= `PCORE_RESET_PC;
        end else begin
            pc_ff <= pc_next;
        end
    end

    assign pc_o = pc_ff;

    // Trap entry must land on the CSR target in the next cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        fwd2if_i.csr_new_pc_req |=> (pc_o == $past(csr_target_i)))
        else $error("CSR redirect did not reach the fetch PC");

endmodule : pc_redirect

`default_nettype wire

// File: source/hazard_unit.sv
// Top of the hazard slice, wiring the hazard detector to the operand bypass and the fetch PC
`default_nettype none

module hazard_unit import pcore_types_pkg::*, pcore_fwd_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst_n,

    // Stage summaries
    input  wire type_exe2fwd_s exe2fwd_i,
    input  wire type_lsu2fwd_s lsu2fwd_i,
    input  wire type_wrb2fwd_s wrb2fwd_i,
    input  wire type_csr2fwd_s csr2fwd_i,

    // Operand sources
    input  wire type_data_t    rf_rs1_data_i,
    input  wire type_data_t    rf_rs2_data_i,
    input  wire type_data_t    lsu_rd_data_i,
    input  wire type_data_t    wrb_rd_data_i,

    // Redirect targets
    input  wire type_pc_t      exe_target_i,
    input  wire type_pc_t      csr_target_i,

    output type_data_t         rs1_data_o,
    output type_data_t         rs2_data_o,
    output type_pc_t           pc_o,

    // Pipeline register controls and CSR stall
    output type_fwd2ptop_s     fwd2ptop_o,
    output type_fwd2csr_s      fwd2csr_o
);

    type_fwd2if_s  fwd2if;
    type_fwd2exe_s fwd2exe;

    forward_stall forward_stall_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wrb2fwd_i  (wrb2fwd_i),
        .lsu2fwd_i  (lsu2fwd_i),
        .exe2fwd_i  (exe2fwd_i),
        .csr2fwd_i  (csr2fwd_i),
        .fwd2if_o   (fwd2if),
        .fwd2exe_o  (fwd2exe),
        .fwd2csr_o  (fwd2csr_o),
        .fwd2ptop_o (fwd2ptop_o)
    );

    // Zero-cycle operand resolution for execute
    operand_bypass operand_bypass_i (
        .fwd2exe_i     (fwd2exe),
        .rf_rs1_data_i (rf_rs1_data_i),
        .rf_rs2_data_i (rf_rs2_data_i),
        .lsu_rd_data_i (lsu_rd_data_i),
        .wrb_rd_data_i (wrb_rd_data_i),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o)
    );

    // Next fetch address, one cycle behind the controls
    pc_redirect pc_redirect_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .fwd2if_i     (fwd2if),
        .exe_target_i (exe_target_i),
        .csr_target_i (csr_target_i),
        .pc_o         (pc_o)
    );

endmodule : hazard_unit

`default_nettype wire

// File: verif/tb_clock_gen.sv
// Free-running testbench clock with a 10-unit period, instantiated by the testbench top
`default_nettype none

module tb_clock_gen (
    output logic clk_o
);

    localparam int HALF_PERIOD = 5;

    initial begin
        clk_o = 1'b0;
    end

    // Toggle every half period
    always begin
        #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule : tb_clock_gen

`default_nettype wire

// File: verif/hazard_unit_tb.sv
// Directed testbench for the hazard slice, compiled as the simulation top through the file list
`default_nettype none

`include "pcore_config.svh"

module hazard_unit_tb import pcore_types_pkg::*, pcore_fwd_pkg::*; ();

    // Roughly 100 cycles of tests, the limit leaves a wide margin
    localparam int RUN_CYCLES_EST = 100;
    localparam int TIMEOUT_CYCLES = 20 * RUN_CYCLES_EST;

    logic           clk;
    logic           rst_n;
    type_exe2fwd_s  exe2fwd;
    type_lsu2fwd_s  lsu2fwd;
    type_wrb2fwd_s  wrb2fwd;
    type_csr2fwd_s  csr2fwd;
    type_data_t     rf_rs1_data;
    type_data_t     rf_rs2_data;
    type_data_t     lsu_rd_data;
    type_data_t     wrb_rd_data;
    type_pc_t       exe_target;
    type_pc_t       csr_target;
    type_data_t     rs1_data;
    type_data_t     rs2_data;
    type_pc_t       pc;
    type_fwd2ptop_s fwd2ptop;
    type_fwd2csr_s  fwd2csr;

    // Fetch PC expected in the current cycle
    type_pc_t       exp_pc;
    int             error_count;
    int             cycle_count;

    tb_clock_gen clock_gen_i (
        .clk_o (clk)
    );

    hazard_unit hazard_unit_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .exe2fwd_i     (exe2fwd),
        .lsu2fwd_i     (lsu2fwd),
        .wrb2fwd_i     (wrb2fwd),
        .csr2fwd_i     (csr2fwd),
        .rf_rs1_data_i (rf_rs1_data),
        .rf_rs2_data_i (rf_rs2_data),
        .lsu_rd_data_i (lsu_rd_data),
        .wrb_rd_data_i (wrb_rd_data),
        .exe_target_i  (exe_target),
        .csr_target_i  (csr_target),
        .rs1_data_o    (rs1_data),
        .rs2_data_o    (rs2_data),
        .pc_o          (pc),
        .fwd2ptop_o    (fwd2ptop),
        .fwd2csr_o     (fwd2csr)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t: %s, got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // Front means the IF/ID and ID/EXE registers, which always move together
    function automatic type_fwd2ptop_s pipe_ctrl(input logic front_stall, input logic front_flush,
                                                 input logic lsu_stall, input logic lsu_flush,
                                                 input logic wrb_rs1, input logic wrb_rs2);
        type_fwd2ptop_s ctrl;
        ctrl.if2id_pipe_stall   = front_stall;
        ctrl.if2id_pipe_flush   = front_flush;
        ctrl.id2exe_pipe_stall  = front_stall;
        ctrl.id2exe_pipe_flush  = front_flush;
        ctrl.exe2lsu_pipe_stall = lsu_stall;
        ctrl.exe2lsu_pipe_flush = lsu_flush;
        ctrl.pipe_fwd_wrb_rs1   = wrb_rs1;
        ctrl.pipe_fwd_wrb_rs2   = wrb_rs2;
        return ctrl;
    endfunction

    task automatic check_controls(input type_fwd2ptop_s exp_ptop, input logic exp_csr_stall,
                                  input string what);
        check_value(32'(fwd2ptop), 32'(exp_ptop), {what, " pipeline controls"});
        check_value(32'(fwd2csr), 32'(exp_csr_stall), {what, " CSR stall"});
    endtask

    task automatic check_pc(input string what);
        check_value(pc, exp_pc, {what, " fetch PC"});
    endtask

    task automatic drive_idle();
        exe2fwd     <= '0;
        lsu2fwd     <= '0;
        wrb2fwd     <= '0;
        csr2fwd     <= '0;
        rf_rs1_data <= '0;
        rf_rs2_data <= '0;
        lsu_rd_data <= '0;
        wrb_rd_data <= '0;
        exe_target  <= '0;
        csr_target  <= '0;
    endtask

    task automatic run_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            drive_idle();
            @(negedge clk);
            check_pc("idle");
            check_controls('0, 1'b0, "idle");
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic test_reset_and_sequence();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        exp_pc = `PCORE_RESET_PC;
        check_pc("after reset");
        check_controls('0, 1'b0, "after reset");
        exp_pc = exp_pc + 32'd4;
        run_idle(8);
    endtask

    task automatic test_forwarding();
        type_reg_addr_t rs1;
        type_reg_addr_t rs2;
        type_data_t     rf1;
        type_data_t     rf2;
        type_data_t     lsu_word;
        type_data_t     wrb_word;
        type_data_t     exp1;
        type_data_t     exp2;
        logic           wrb1;
        logic           wrb2;
        for (int i = 0; i < 24; i++) begin
            rs1      = type_reg_addr_t'($urandom_range(31, 1));
            // Second index differs from the first and is never x0
            rs2      = (rs1 % 5'd31) + 5'd1;
            rf1      = $urandom();
            rf2      = $urandom();
            lsu_word = $urandom();
            wrb_word = $urandom();
            exp1     = rf1;
            exp2     = rf2;
            wrb1     = 1'b0;
            wrb2     = 1'b0;
            @(posedge clk);
            drive_idle();
            exe2fwd.rs1_addr <= rs1;
            exe2fwd.rs2_addr <= rs2;
            exe2fwd.use_rs1  <= 1'b1;
            exe2fwd.use_rs2  <= 1'b1;
            rf_rs1_data      <= rf1;
            rf_rs2_data      <= rf2;
            lsu_rd_data      <= lsu_word;
            wrb_rd_data      <= wrb_word;
            case (i % 4)
                0: begin
                    lsu2fwd.rd_addr   <= rs1;
                    lsu2fwd.rd_wr_req <= 1'b1;
                    exp1 = lsu_word;
                end
                1: begin
                    wrb2fwd.rd_addr   <= rs2;
                    wrb2fwd.rd_wr_req <= 1'b1;
                    exp2 = wrb_word;
                    wrb2 = 1'b1;
                end
                2: begin
                    // Both producers hit rs1, the LSU one is younger
                    lsu2fwd.rd_addr   <= rs1;
                    lsu2fwd.rd_wr_req <= 1'b1;
                    wrb2fwd.rd_addr   <= rs1;
                    wrb2fwd.rd_wr_req <= 1'b1;
                    exp1 = lsu_word;
                    wrb1 = 1'b1;
                end
                default: begin
                    exe2fwd.rs1_addr  <= '0;
                    exe2fwd.rs2_addr  <= '0;
                    lsu2fwd.rd_wr_req <= 1'b1;
                    wrb2fwd.rd_wr_req <= 1'b1;
                end
            endcase
            @(negedge clk);
            check_value(rs1_data, exp1, "forwarded rs1");
            check_value(rs2_data, exp2, "forwarded rs2");
            check_controls(pipe_ctrl(1'b0, 1'b0, 1'b0, 1'b0, wrb1, wrb2), 1'b0, "forwarding");
            check_pc("forwarding");
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic test_load_use();
        type_reg_addr_t rd;
        type_data_t     rf1;
        type_data_t     lsu_word;
        rd       = type_reg_addr_t'($urandom_range(31, 1));
        rf1      = $urandom();
        lsu_word = ~rf1;
        // Cycle 0 issues the load, cycles 1 to 3 wait, cycle 4 is the ack
        for (int cyc = 0; cyc < 5; cyc++) begin
            @(posedge clk);
            drive_idle();
            exe2fwd.rs1_addr  <= rd;
            exe2fwd.use_rs1   <= 1'b1;
            lsu2fwd.rd_addr   <= rd;
            lsu2fwd.rd_wr_req <= 1'b1;
            lsu2fwd.ld_req    <= (cyc < 4);
            lsu2fwd.ld_ack    <= (cyc == 4);
            rf_rs1_data       <= rf1;
            lsu_rd_data       <= lsu_word;
            @(negedge clk);
            check_pc("load-use");
            if (cyc == 0) begin
                check_controls(pipe_ctrl(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0), 1'b1,
                               "load-use hazard");
                check_value(rs1_data, rf1, "load-use rs1");
            end else if (cyc < 4) begin
                check_controls(pipe_ctrl(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0), 1'b0,
                               "load stall");
                check_value(rs1_data, rf1, "load stall rs1");
            end else begin
                check_controls('0, 1'b0, "load ack");
                check_value(rs1_data, lsu_word, "load ack rs1");
                exp_pc = exp_pc + 32'd4;
            end
        end
        run_idle(2);
    endtask

    task automatic test_multiply();
        for (int cyc = 0; cyc < 5; cyc++) begin
            @(posedge clk);
            drive_idle();
            lsu2fwd.mul_req   <= (cyc == 0);
            wrb2fwd.alu_m_res <= (cyc == 4);
            @(negedge clk);
            check_pc("multiply");
            if (cyc < 4) begin
                check_controls(pipe_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0,
                               "multiply stall");
            end else begin
                check_controls('0, 1'b0, "multiply result");
                exp_pc = exp_pc + 32'd4;
            end
        end
        run_idle(2);
    endtask

    task automatic test_redirects();
        type_pc_t target;
        type_pc_t other;
        target = type_pc_t'($urandom()) & 32'hffff_fffc;
        @(posedge clk);
        drive_idle();
        exe2fwd.new_pc_req <= 1'b1;
        exe_target         <= target;
        @(negedge clk);
        check_pc("execute redirect");
        check_controls(pipe_ctrl(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0, "execute redirect");
        exp_pc = target;
        run_idle(2);

        // Redirect while a load is outstanding must be dropped
        target = type_pc_t'($urandom()) & 32'hffff_fffc;
        for (int cyc = 0; cyc < 3; cyc++) begin
            @(posedge clk);
            drive_idle();
            lsu2fwd.ld_req     <= (cyc < 2);
            lsu2fwd.ld_ack     <= (cyc == 2);
            exe2fwd.new_pc_req <= (cyc == 1);
            exe_target         <= target;
            @(negedge clk);
            check_pc("redirect during load");
            if (cyc < 2) begin
                check_controls(pipe_ctrl(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0), 1'b0,
                               "redirect during load");
            end else begin
                check_controls('0, 1'b0, "ack after dropped redirect");
                exp_pc = exp_pc + 32'd4;
            end
        end
        run_idle(2);

        target = type_pc_t'($urandom()) & 32'hffff_fffc;
        other  = ~target & 32'hffff_fffc;
        @(posedge clk);
        drive_idle();
        exe2fwd.new_pc_req <= 1'b1;
        exe_target         <= other;
        csr2fwd.new_pc_req <= 1'b1;
        csr_target         <= target;
        @(negedge clk);
        check_pc("CSR redirect");
        check_controls(pipe_ctrl(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0), 1'b0, "CSR redirect");
        exp_pc = target;
        run_idle(2);

        repeat (3) begin
            @(posedge clk);
            drive_idle();
            csr2fwd.wfi_req <= 1'b1;
            @(negedge clk);
            check_pc("wfi");
            check_controls(pipe_ctrl(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0), 1'b0, "wfi");
        end
        run_idle(2);
    endtask

    initial begin
        void'($urandom(32'h3249fd44));
        error_count = 0;
        exp_pc      = '0;
        rst_n <= 1'b0;
        drive_idle();
        test_reset_and_sequence();
        test_forwarding();
        test_load_use();
        test_multiply();
        test_redirects();
        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: the run timed out after %0d cycles", cycle_count);
        $display("Simulation failed");
        $finish;
    end

endmodule : hazard_unit_tb

`default_nettype wire

// File: hazard_unit.f
+incdir+source
source/pcore_types_pkg.sv
source/pcore_fwd_pkg.sv
source/forward_stall.sv
source/operand_bypass.sv
source/pc_redirect.sv
source/hazard_unit.sv
verif/tb_clock_gen.sv
verif/hazard_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the hazard unit testbench with Verilator, runs it and reports pass or fail

cd "$(dirname "$0")" || exit 1

PASS_MSG="Simulation completed successfully"
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f hazard_unit.f \
    --top-module hazard_unit_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$("./$BUILD_DIR/Vhazard_unit_tb" 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "Simulation run returned status $sim_status"
    exit 1
fi

if grep -qF "$PASS_MSG" <<< "$sim_output"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
